//--- vlog.f
+incdir+tb
source/issue_pkg.sv
source/field_decoder.sv
source/operand_resolver.sv
source/issue_controller.sv
source/issue_unit.sv
tb/tb_issue_unit.sv

//--- tb/issue_table.svh
// Columns are instr, pc, predicted taken, full {rob, alu, bcu}, chained, flush,
// CDB tag, CDB value, expected strobes {fetch, rob, alu, bcu, rename}
add_row(32'h123450B7, 32'h0000_0100, 1'b0, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b01001); // LUI x1
add_row(32'hABCDE117, 32'h0000_0104, 1'b0, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b01101); // AUIPC x2
// ADD x3, x5, x6 with x6 on the CDB
add_row(32'h006281B3, 32'h0000_0108, 1'b0, 3'b000, 1'b0, 1'b0, 4'd3, 32'h0000_CAFE, 5'b01101);
// SUB x4, x7, x8 with x7 ready in the ROB and x8 pending
add_row(32'h40838233, 32'h0000_010C, 1'b0, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b01101);
add_row(32'hFFB00493, 32'h0000_0110, 1'b0, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b01101); // ADDI x9, x0
add_row(32'h4072D513, 32'h0000_0114, 1'b0, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b01101); // SRAI x10
add_row(32'h06462593, 32'h0000_0118, 1'b0, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b01101); // SLTI x11
// ADD x13, x11, x5 right behind SLTI, so x11 comes back as a tag
add_row(32'h005586B3, 32'h0000_011C, 1'b0, 3'b000, 1'b1, 1'b0, 4'd0, 32'h0, 5'b01101);
add_row(32'h00ABC737, 32'h0000_0120, 1'b0, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b01001); // LUI x14
// ADDI x15, x14, 1 right behind LUI, value forwarded
add_row(32'h00170793, 32'h0000_0124, 1'b0, 3'b000, 1'b1, 1'b0, 4'd0, 32'h0, 5'b01101);
add_row(32'h0400006F, 32'h0000_0128, 1'b0, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b11000); // JAL x0
add_row(32'h02628063, 32'h0000_0168, 1'b1, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b11010); // BEQ taken
add_row(32'hFE8398E3, 32'h0000_0188, 1'b0, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b11010); // BNE
// Back-pressure from each full flag
add_row(32'h00728833, 32'h0000_018C, 1'b0, 3'b010, 1'b0, 1'b0, 4'd0, 32'h0, 5'b01101); // ADD x16
add_row(32'h0072C463, 32'h0000_0190, 1'b1, 3'b001, 1'b0, 1'b0, 4'd0, 32'h0, 5'b11010); // BLT
add_row(32'h555558B7, 32'h0000_0198, 1'b0, 3'b100, 1'b0, 1'b0, 4'd0, 32'h0, 5'b01001); // LUI x17
// ADD x18 held on a full ROB and then flushed
add_row(32'h00628933, 32'h0000_019C, 1'b0, 3'b100, 1'b0, 1'b1, 4'd0, 32'h0, 5'b00000);
add_row(32'h0000_0000, 32'h0000_01A0, 1'b0, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b00000); // Unknown
add_row(32'h7FF28993, 32'h0000_01A4, 1'b0, 3'b000, 1'b0, 1'b0, 4'd0, 32'h0, 5'b01101); // ADDI x19

//--- tb/tb_issue_unit.sv
`timescale 1ns/1ns

module tb_issue_unit;
    import issue_pkg::*;

    localparam int ROB_DEPTH = 16;
    localparam int TIMEOUT   = 20;
    localparam int HOLD      = 2;   // Extra stalled cycles before the full flag drops
    localparam int MAX_ROWS  = 32;

    logic     clk_in = 1'b0;
    logic     arst_n, flush, instruction_valid, fetch_pred_taken;
    logic     rob_full, rs_alu_full, rs_bcu_full;
    word_t    fetch_instr, fetch_pc, cdb_alu_value;
    rob_id_t  next_rob_id, cdb_alu_rob_id;
    rob_id_t  regfile_rob_id [NUM_REGS];
    word_t    regfile_data [NUM_REGS];
    word_t    rob_values [ROB_DEPTH];
    logic     rob_ready [ROB_DEPTH];

    logic     fetcher_enabled, rob_enabled, rs_alu_enabled, rs_bcu_enabled, regfile_enabled;
    logic     rob_value_ready, rob_pred_taken;
    rob_op_t  rob_op;
    alu_op_t  rs_alu_op;
    bcu_op_t  rs_bcu_op;
    reg_idx_t regfile_reg_id;
    word_t    fetcher_pc, rob_value, rob_alt_value, rs_alu_vj, rs_alu_vk;
    word_t    rs_bcu_vj, rs_bcu_vk, rs_bcu_pc_fallthrough, rs_bcu_pc_target;
    rob_id_t  rob_dest, rs_alu_qj, rs_alu_qk, rs_alu_dest;
    rob_id_t  rs_bcu_qj, rs_bcu_qk, rs_bcu_dest, regfile_rob_id_out;

    // Stimulus table
    word_t    t_instr [MAX_ROWS];
    word_t    t_pc [MAX_ROWS];
    word_t    t_cdb_val [MAX_ROWS];
    rob_id_t  t_cdb_id [MAX_ROWS];
    logic     t_pred [MAX_ROWS];
    logic     t_chain [MAX_ROWS];   // Presented right behind the row before
    logic     t_flush [MAX_ROWS];
    logic [2:0] t_full [MAX_ROWS];  // {rob, alu, bcu}
    logic [4:0] t_exp [MAX_ROWS];   // {fetch, rob, alu, bcu, rename}
    int       n_rows = 0;

    // Rename issued by the row before
    logic     last_valid, last_ready;
    reg_idx_t last_reg;
    rob_id_t  last_tag;
    word_t    last_value;

    int       seed;
    int       errors = 0;

    issue_unit #(.ROB_DEPTH(ROB_DEPTH)) UUT (.*);

    always #4 clk_in = ~clk_in;

    task automatic add_row(input word_t instr, input word_t pc, input logic pred,
                           input logic [2:0] full, input logic chain, input logic flush_row,
                           input rob_id_t cdb_id, input word_t cdb_val, input logic [4:0] exp);
        t_instr[n_rows]   = instr;
        t_pc[n_rows]      = pc;
        t_pred[n_rows]    = pred;
        t_full[n_rows]    = full;
        t_chain[n_rows]   = chain;
        t_flush[n_rows]   = flush_row;
        t_cdb_id[n_rows]  = cdb_id;
        t_cdb_val[n_rows] = cdb_val;
        t_exp[n_rows]     = exp;
        n_rows++;
    endtask

    task automatic build_table;
        `include "issue_table.svh"
    endtask

    function automatic rob_id_t tag_of(input int i);
        return rob_id_t'(i % 15 + 1);   // Never tag 0
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_tag(input string name, input rob_id_t got, input rob_id_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_op(input string name, input alu_op_t got, input alu_op_t exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_strobes(input logic [4:0] exp);
        check_bit("fetcher_enabled", fetcher_enabled, exp[4]);
        check_bit("rob_enabled", rob_enabled, exp[3]);
        check_bit("rs_alu_enabled", rs_alu_enabled, exp[2]);
        check_bit("rs_bcu_enabled", rs_bcu_enabled, exp[1]);
        check_bit("regfile_enabled", regfile_enabled, exp[0]);
    endtask

    // Source operand in priority order x0, last rename, register file, CDB, ready ROB, pending
    task automatic resolve(input reg_idx_t r, input int i, output word_t v, output rob_id_t q);
        rob_id_t rt;
        rt = regfile_rob_id[r];
        v  = '0;
        q  = '0;
        if (r != '0) begin
            if (t_chain[i] && last_valid && last_reg == r) begin
                if (last_ready) v = last_value;
                else q = last_tag;
            end else if (rt == '0) begin
                v = regfile_data[r];
            end else if (t_cdb_id[i] == rt) begin
                v = t_cdb_val[i];
            end else if (rob_ready[rt]) begin
                v = rob_values[rt];
            end else begin
                q = rt;
            end
        end
    endtask

    task automatic check_issue(input int i);
        word_t   in, pc, v1, v2, i_imm, u_imm, b_tgt, j_tgt, exp_fpc, exp_vk;
        rob_id_t q1, q2, tag;
        opcode_t opc;
        logic [2:0] f3;
        logic    shift;
        alu_op_t exp_op;
        in    = t_instr[i];
        pc    = t_pc[i];
        opc   = in[6:0];
        f3    = in[14:12];
        tag   = tag_of(i);
        shift = (opc == OPC_OP_IMM) && (f3 == 3'b001 || f3 == 3'b101);
        i_imm = {{20{in[31]}}, in[31:20]};
        u_imm = {in[31:12], 12'b0};
        b_tgt = pc + {{19{in[31]}}, in[31], in[7], in[30:25], in[11:8], 1'b0};
        j_tgt = pc + {{11{in[31]}}, in[31], in[19:12], in[20], in[30:21], 1'b0};
        resolve(in[19:15], i, v1, q1);
        resolve(in[24:20], i, v2, q2);
        check_strobes(t_exp[i]);
        if (opc == OPC_JAL) exp_fpc = j_tgt;
        else exp_fpc = t_pred[i] ? b_tgt : pc + 4;
        if (fetcher_enabled) check_word("fetcher_pc", fetcher_pc, exp_fpc);
        if (rob_enabled) begin
            check_tag("rob_dest", rob_dest, tag);
            check_bit("rob_op", rob_op, opc == OPC_BRANCH);
            check_bit("rob_value_ready", rob_value_ready, opc == OPC_LUI || opc == OPC_JAL);
            if (opc == OPC_LUI) check_word("rob_value", rob_value, u_imm);
            if (opc == OPC_JAL) check_word("rob_value", rob_value, pc + 4);   // Link
            if (opc == OPC_BRANCH) begin
                check_word("rob_alt_value", rob_alt_value, pc);
                check_bit("rob_pred_taken", rob_pred_taken, t_pred[i]);
            end
        end
        if (rs_alu_enabled) begin
            if (opc == OPC_OP || shift) exp_op = {in[30], f3};
            else exp_op = (opc == OPC_AUIPC) ? 4'b0 : {1'b0, f3};
            if (opc == OPC_OP) exp_vk = v2;
            else if (opc == OPC_AUIPC) exp_vk = u_imm;
            else exp_vk = shift ? {27'b0, in[24:20]} : i_imm;
            check_op("rs_alu_op", rs_alu_op, exp_op);
            check_word("rs_alu_vj", rs_alu_vj, (opc == OPC_AUIPC) ? pc : v1);
            check_tag("rs_alu_qj", rs_alu_qj, (opc == OPC_AUIPC) ? '0 : q1);
            check_word("rs_alu_vk", rs_alu_vk, exp_vk);
            check_tag("rs_alu_qk", rs_alu_qk, (opc == OPC_OP) ? q2 : '0);
            check_tag("rs_alu_dest", rs_alu_dest, tag);
        end
        if (rs_bcu_enabled) begin
            check_op("rs_bcu_op", {1'b0, rs_bcu_op}, {1'b0, f3});
            check_word("rs_bcu_vj", rs_bcu_vj, v1);
            check_word("rs_bcu_vk", rs_bcu_vk, v2);
            check_tag("rs_bcu_qj", rs_bcu_qj, q1);
            check_tag("rs_bcu_qk", rs_bcu_qk, q2);
            check_tag("rs_bcu_dest", rs_bcu_dest, tag);
            check_word("rs_bcu_pc_fallthrough", rs_bcu_pc_fallthrough, pc + 4);
            check_word("rs_bcu_pc_target", rs_bcu_pc_target, b_tgt);
        end
        if (regfile_enabled) begin
            check_word("regfile_reg_id", {27'b0, regfile_reg_id}, {27'b0, in[11:7]});
            check_tag("regfile_rob_id_out", regfile_rob_id_out, tag);
        end
        last_valid = t_exp[i][0];
        last_reg   = in[11:7];
        last_tag   = tag;
        last_ready = (opc == OPC_LUI) || (opc == OPC_JAL);
        last_value = (opc == OPC_LUI) ? u_imm : pc + 4;
    endtask

    task automatic drive_row(input int i);
        instruction_valid <= 1'b1;
        fetch_instr       <= t_instr[i];
        fetch_pc          <= t_pc[i];
        fetch_pred_taken  <= t_pred[i];
        {rob_full, rs_alu_full, rs_bcu_full} <= t_full[i];
        cdb_alu_rob_id    <= t_cdb_id[i];
        cdb_alu_value     <= t_cdb_val[i];
        next_rob_id       <= tag_of(i);
    endtask

    task automatic run_row(input int i);
        int      cycles;
        logic    stalls;
        logic    redirect;
        redirect = (t_instr[i][6:0] == OPC_JAL) || (t_instr[i][6:0] == OPC_BRANCH);
        stalls   = |t_full[i];
        if (!t_chain[i]) begin
            @(posedge clk_in);
            drive_row(i);
        end
        @(posedge clk_in);   // DUT takes the row here
        if (i + 1 < n_rows && t_chain[i + 1]) drive_row(i + 1);
        else if (!redirect || stalls) instruction_valid <= 1'b0;
        if (stalls) begin
            // Fetcher moves on while the stalled one waits
            fetch_instr      <= '0;
            fetch_pc         <= t_pc[i] + 4;
            fetch_pred_taken <= !t_pred[i];
        end
        if (stalls) begin
            repeat (HOLD + 1) begin
                @(negedge clk_in);
                check_strobes(5'b10000);
                check_word("fetcher_pc", fetcher_pc, t_pc[i] + 4);
            end
            @(posedge clk_in);
            if (t_flush[i]) begin
                flush <= 1'b1;
                @(posedge clk_in);
                flush <= 1'b0;
            end
            {rob_full, rs_alu_full, rs_bcu_full} <= '0;
        end
        if (t_exp[i] == '0) begin
            repeat (2) begin
                @(negedge clk_in);
                check_strobes('0);
            end
        end else begin
            cycles = 0;
            do begin
                @(negedge clk_in);
                cycles++;
            end while (!rob_enabled && cycles < TIMEOUT);
            if (!rob_enabled) begin
                $display("Timeout while waiting for row %0d to issue", i);
                errors++;
            end else begin
                if (cycles != (stalls ? 2 : 1)) begin
                    $display("Row %0d issued after %0d cycles instead of %0d", i, cycles,
                             stalls ? 2 : 1);
                    errors++;
                end
                check_issue(i);
                if (redirect) begin
                    @(posedge clk_in);
                    instruction_valid <= 1'b0;
                    @(negedge clk_in);
                    check_strobes('0);   // Skip slot
                end
            end
        end
    endtask

    initial begin
        seed              = 75643;
        arst_n            = 1'b0;
        flush             = 1'b0;
        instruction_valid = 1'b0;
        fetch_instr       = '0;
        fetch_pc          = '0;
        fetch_pred_taken  = 1'b0;
        {rob_full, rs_alu_full, rs_bcu_full} = '0;
        next_rob_id       = '0;
        cdb_alu_rob_id    = '0;
        cdb_alu_value     = '0;
        last_valid        = 1'b0;
        for (int r = 0; r < NUM_REGS; r++) begin
            regfile_data[r]   = $random(seed);
            regfile_rob_id[r] = ($random(seed) & 1) ? rob_id_t'($random(seed)) : '0;
        end
        for (int e = 0; e < ROB_DEPTH; e++) begin
            rob_values[e] = $random(seed);
            rob_ready[e]  = $random(seed) & 1;
        end
        // x5 committed, x6 on the CDB, x7 done in ROB, x8 pending
        regfile_rob_id[5] = 4'd0;
        regfile_rob_id[6] = 4'd3;
        rob_ready[3]      = 1'b0;
        regfile_rob_id[7] = 4'd4;
        rob_ready[4]      = 1'b1;
        regfile_rob_id[8] = 4'd5;
        rob_ready[5]      = 1'b0;
        build_table();
        repeat (8) @(posedge clk_in);
        arst_n <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end
        repeat (2) @(posedge clk_in);
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- source/issue_unit.sv
`timescale 1ns/1ns

module issue_unit #(
    parameter int ROB_DEPTH = 16
) (
    input  logic                clk_in,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                instruction_valid,
    input  issue_pkg::word_t    fetch_instr,
    input  issue_pkg::word_t    fetch_pc,
    input  logic                fetch_pred_taken,
    input  issue_pkg::rob_id_t  regfile_rob_id [issue_pkg::NUM_REGS],
    input  issue_pkg::word_t    regfile_data [issue_pkg::NUM_REGS],
    input  issue_pkg::word_t    rob_values [ROB_DEPTH],
    input  logic                rob_ready [ROB_DEPTH],
    input  logic                rob_full,
    input  issue_pkg::rob_id_t  next_rob_id,
    input  issue_pkg::rob_id_t  cdb_alu_rob_id,
    input  issue_pkg::word_t    cdb_alu_value,
    input  logic                rs_alu_full,
    input  logic                rs_bcu_full,
    output logic                fetcher_enabled,
    output issue_pkg::word_t    fetcher_pc,
    output logic                rob_enabled,
    output issue_pkg::rob_op_t  rob_op,
    output logic                rob_value_ready,
    output issue_pkg::word_t    rob_value,
    output issue_pkg::word_t    rob_alt_value,
    output issue_pkg::rob_id_t  rob_dest,
    output logic                rob_pred_taken,
    output logic                rs_alu_enabled,
    output issue_pkg::alu_op_t  rs_alu_op,
    output issue_pkg::word_t    rs_alu_vj,
    output issue_pkg::word_t    rs_alu_vk,
    output issue_pkg::rob_id_t  rs_alu_qj,
    output issue_pkg::rob_id_t  rs_alu_qk,
    output issue_pkg::rob_id_t  rs_alu_dest,
    output logic                rs_bcu_enabled,
    output issue_pkg::bcu_op_t  rs_bcu_op,
    output issue_pkg::word_t    rs_bcu_vj,
    output issue_pkg::word_t    rs_bcu_vk,
    output issue_pkg::rob_id_t  rs_bcu_qj,
    output issue_pkg::rob_id_t  rs_bcu_qk,
    output issue_pkg::rob_id_t  rs_bcu_dest,
    output issue_pkg::word_t    rs_bcu_pc_fallthrough,
    output issue_pkg::word_t    rs_bcu_pc_target,
    output logic                regfile_enabled,
    output issue_pkg::reg_idx_t regfile_reg_id,
    output issue_pkg::rob_id_t  regfile_rob_id_out
);
    import issue_pkg::*;

    // Instruction under decode
    word_t    instr;
    word_t    pc;
    logic     pred_taken;
    word_t    held_instr;
    word_t    held_pc;
    logic     held_pred_taken;
    logic     in_held_state;

    opcode_t  opcode;
    reg_idx_t rd;
    reg_idx_t rs1;
    reg_idx_t rs2;
    alu_op_t  alu_op;
    bcu_op_t  bcu_op;
    word_t    alu_imm_operand;
    word_t    u_imm;
    word_t    pc_plus4;
    word_t    jal_target;
    word_t    branch_target;
    logic     uses_rs2;
    word_t    rs1_value;
    rob_id_t  rs1_tag;
    word_t    rs2_value;
    rob_id_t  rs2_tag;

    // Retry takes the stalled copy, otherwise the fetcher's word
    assign instr      = in_held_state ? held_instr : fetch_instr;
    assign pc         = in_held_state ? held_pc : fetch_pc;
    assign pred_taken = in_held_state ? held_pred_taken : fetch_pred_taken;

    field_decoder u_decoder (.*);

    operand_resolver #(
        .ROB_DEPTH(ROB_DEPTH)
    ) u_resolver (
        .last_rename_valid (regfile_enabled),    // Previous cycle's rename
        .last_rename_reg   (regfile_reg_id),
        .last_rename_tag   (regfile_rob_id_out),
        .last_value_ready  (rob_value_ready),
        .last_value        (rob_value),
        .*
    );

    issue_controller u_controller (.*);

endmodule

//--- source/issue_controller.sv
`timescale 1ns/1ns

module issue_controller (
    input  logic                clk_in,
    input  logic                arst_n,
    input  logic                flush,
    input  logic                instruction_valid,
    input  issue_pkg::word_t    instr,
    input  issue_pkg::word_t    pc,
    input  logic                pred_taken,
    input  issue_pkg::opcode_t  opcode,
    input  issue_pkg::reg_idx_t rd,
    input  issue_pkg::alu_op_t  alu_op,
    input  issue_pkg::bcu_op_t  bcu_op,
    input  issue_pkg::word_t    alu_imm_operand,
    input  issue_pkg::word_t    u_imm,
    input  issue_pkg::word_t    pc_plus4,
    input  issue_pkg::word_t    jal_target,
    input  issue_pkg::word_t    branch_target,
    input  logic                uses_rs2,
    input  issue_pkg::word_t    rs1_value,
    input  issue_pkg::rob_id_t  rs1_tag,
    input  issue_pkg::word_t    rs2_value,
    input  issue_pkg::rob_id_t  rs2_tag,
    input  logic                rob_full,
    input  logic                rs_alu_full,
    input  logic                rs_bcu_full,
    input  issue_pkg::rob_id_t  next_rob_id,
    output logic                fetcher_enabled,
    output issue_pkg::word_t    fetcher_pc,
    output logic                rob_enabled,
    output issue_pkg::rob_op_t  rob_op,
    output logic                rob_value_ready,
    output issue_pkg::word_t    rob_value,
    output issue_pkg::word_t    rob_alt_value,
    output issue_pkg::rob_id_t  rob_dest,
    output logic                rob_pred_taken,
    output logic                rs_alu_enabled,
    output issue_pkg::alu_op_t  rs_alu_op,
    output issue_pkg::word_t    rs_alu_vj,
    output issue_pkg::word_t    rs_alu_vk,
    output issue_pkg::rob_id_t  rs_alu_qj,
    output issue_pkg::rob_id_t  rs_alu_qk,
    output issue_pkg::rob_id_t  rs_alu_dest,
    output logic                rs_bcu_enabled,
    output issue_pkg::bcu_op_t  rs_bcu_op,
    output issue_pkg::word_t    rs_bcu_vj,
    output issue_pkg::word_t    rs_bcu_vk,
    output issue_pkg::rob_id_t  rs_bcu_qj,
    output issue_pkg::rob_id_t  rs_bcu_qk,
    output issue_pkg::rob_id_t  rs_bcu_dest,
    output issue_pkg::word_t    rs_bcu_pc_fallthrough,
    output issue_pkg::word_t    rs_bcu_pc_target,
    output logic                regfile_enabled,
    output issue_pkg::reg_idx_t regfile_reg_id,
    output issue_pkg::rob_id_t  regfile_rob_id_out,
    output issue_pkg::word_t    held_instr,
    output issue_pkg::word_t    held_pc,
    output logic                held_pred_taken,
    output logic                in_held_state
);
    import issue_pkg::*;

    issue_state_t state;
    issue_state_t state_next;
    logic         attempt;    // An instruction is up for issue this cycle
    logic         known_op;
    logic         need_alu;
    logic         need_bcu;
    logic         writes_rd;
    logic         redirect;   // JAL or branch
    logic         stall;
    logic         go;
    word_t        fetch_pc_next;

    assign in_held_state = (state == ST_ISSUE_HELD);

    // Flush kills the attempt, so nothing issues and the state falls back to try
    assign attempt = !flush && (in_held_state || (state == ST_TRY_ISSUE && instruction_valid));

    always_comb begin
        known_op  = 1'b1;
        need_alu  = 1'b0;
        need_bcu  = 1'b0;
        writes_rd = 1'b0;
        case (opcode)
            OPC_LUI, OPC_JAL: writes_rd = 1'b1;
            OPC_AUIPC, OPC_OP_IMM, OPC_OP: begin
                writes_rd = 1'b1;
                need_alu  = 1'b1;
            end
            OPC_BRANCH: need_bcu = 1'b1;
            default:    known_op = 1'b0;
        endcase
    end

    assign redirect = (opcode == OPC_JAL) || (opcode == OPC_BRANCH);
    assign stall = attempt && known_op &&
                   (rob_full || (need_alu && rs_alu_full) || (need_bcu && rs_bcu_full));
    assign go = attempt && known_op && !stall;

    always_comb begin
        if (stall) begin
            state_next = ST_ISSUE_HELD;
        end else if (go && redirect) begin
            state_next = ST_SKIP_ONE;
        end else begin
            state_next = ST_TRY_ISSUE;    // Also the exit from the skip slot
        end
    end

    always_comb begin
        if (stall || opcode == OPC_BRANCH && !pred_taken) begin
            fetch_pc_next = pc_plus4;     // Refetch after the held one, or fall through
        end else if (opcode == OPC_JAL) begin
            fetch_pc_next = jal_target;
        end else begin
            fetch_pc_next = branch_target;
        end
    end

    always_ff @(posedge clk_in or negedge arst_n) begin
        if (!arst_n) begin
            state           <= ST_TRY_ISSUE;
            fetcher_enabled <= 1'b0;
            rob_enabled     <= 1'b0;
            rs_alu_enabled  <= 1'b0;
            rs_bcu_enabled  <= 1'b0;
            regfile_enabled <= 1'b0;
        end else begin
            state           <= state_next;
            fetcher_enabled <= stall || (go && redirect);
            rob_enabled     <= go;
            rs_alu_enabled  <= go && need_alu;
            rs_bcu_enabled  <= go && need_bcu;
            regfile_enabled <= go && writes_rd && (rd != '0);
        end
    end

    // Payloads load every cycle and count only under their strobe
    always_ff @(posedge clk_in) begin
        fetcher_pc      <= fetch_pc_next;
        rob_op          <= (opcode == OPC_BRANCH) ? ROB_OP_BRANCH : ROB_OP_OTHER;
        rob_value_ready <= (opcode == OPC_LUI) || (opcode == OPC_JAL);
        if (opcode == OPC_JAL) begin
            rob_value <= pc_plus4;      // Link address
        end else if (opcode == OPC_LUI) begin
            rob_value <= u_imm;
        end else begin
            rob_value <= '0;
        end
        rob_alt_value  <= (opcode == OPC_BRANCH) ? pc : '0;
        rob_dest       <= next_rob_id;
        rob_pred_taken <= (opcode == OPC_BRANCH) && pred_taken;

        rs_alu_op   <= alu_op;
        rs_alu_vj   <= (opcode == OPC_AUIPC) ? pc : rs1_value;
        rs_alu_qj   <= (opcode == OPC_AUIPC) ? '0 : rs1_tag;
        rs_alu_vk   <= uses_rs2 ? rs2_value : alu_imm_operand;
        rs_alu_qk   <= uses_rs2 ? rs2_tag : '0;
        rs_alu_dest <= next_rob_id;

        rs_bcu_op             <= bcu_op;
        rs_bcu_vj             <= rs1_value;
        rs_bcu_vk             <= rs2_value;
        rs_bcu_qj             <= rs1_tag;
        rs_bcu_qk             <= rs2_tag;
        rs_bcu_dest           <= next_rob_id;
        rs_bcu_pc_fallthrough <= pc_plus4;
        rs_bcu_pc_target      <= branch_target;

        regfile_reg_id     <= rd;
        regfile_rob_id_out <= next_rob_id;

        // Retry buffer
        if (stall) begin
            held_instr      <= instr;
            held_pc         <= pc;
            held_pred_taken <= pred_taken;
        end
    end

endmodule

//--- source/operand_resolver.sv
`timescale 1ns/1ns

module operand_resolver #(
    parameter int ROB_DEPTH = 16
) (
    input  issue_pkg::reg_idx_t rs1,
    input  issue_pkg::reg_idx_t rs2,
    input  issue_pkg::rob_id_t  regfile_rob_id [issue_pkg::NUM_REGS],
    input  issue_pkg::word_t    regfile_data [issue_pkg::NUM_REGS],
    input  issue_pkg::word_t    rob_values [ROB_DEPTH],
    input  logic                rob_ready [ROB_DEPTH],
    input  issue_pkg::rob_id_t  cdb_alu_rob_id,
    input  issue_pkg::word_t    cdb_alu_value,
    input  logic                last_rename_valid,
    input  issue_pkg::reg_idx_t last_rename_reg,
    input  issue_pkg::rob_id_t  last_rename_tag,
    input  logic                last_value_ready,
    input  issue_pkg::word_t    last_value,
    output issue_pkg::word_t    rs1_value,
    output issue_pkg::rob_id_t  rs1_tag,
    output issue_pkg::word_t    rs2_value,
    output issue_pkg::rob_id_t  rs2_tag
);
    import issue_pkg::*;

    // One source register to a value or a pending tag
    function automatic void lookup(
        input  reg_idx_t r,
        output word_t    value,
        output rob_id_t  tag
    );
        rob_id_t rf_tag;
        rf_tag = regfile_rob_id[r];
        value  = '0;
        tag    = '0;
        if (r == '0) begin
            // x0 is hardwired
        end else if (last_rename_valid && last_rename_reg == r) begin
            // Rename from last cycle has not reached the register file yet
            if (last_value_ready) begin
                value = last_value;
            end else begin
                tag = last_rename_tag;
            end
        end else if (rf_tag == '0) begin
            value = regfile_data[r];
        end else if (cdb_alu_rob_id == rf_tag) begin
            value = cdb_alu_value;            // Result on the bus this cycle
        end else if (rob_ready[rf_tag]) begin
            value = rob_values[rf_tag];       // Done but not yet committed
        end else begin
            tag = rf_tag;
        end
    endfunction

    always_comb begin
        lookup(rs1, rs1_value, rs1_tag);
        lookup(rs2, rs2_value, rs2_tag);
    end

endmodule

//--- source/field_decoder.sv
`timescale 1ns/1ns

module field_decoder (
    input  issue_pkg::word_t    instr,
    input  issue_pkg::word_t    pc,
    output issue_pkg::opcode_t  opcode,
    output issue_pkg::reg_idx_t rd,
    output issue_pkg::reg_idx_t rs1,
    output issue_pkg::reg_idx_t rs2,
    output issue_pkg::alu_op_t  alu_op,
    output issue_pkg::bcu_op_t  bcu_op,
    output issue_pkg::word_t    alu_imm_operand,
    output issue_pkg::word_t    u_imm,
    output issue_pkg::word_t    pc_plus4,
    output issue_pkg::word_t    jal_target,
    output issue_pkg::word_t    branch_target,
    output logic                uses_rs2
);
    import issue_pkg::*;

    logic [2:0] funct3;
    logic       is_shift;
    word_t      i_imm;
    word_t      b_imm;
    word_t      j_imm;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign bcu_op = funct3;

    // Sign-extended immediates
    assign i_imm = {{20{instr[31]}}, instr[31:20]};
    assign b_imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign u_imm = {instr[31:12], 12'b0};

    assign pc_plus4      = pc + 32'd4;
    assign jal_target    = pc + j_imm;
    assign branch_target = pc + b_imm;

    assign is_shift = (funct3 == 3'b001) || (funct3 == 3'b101); // SLLI, SRLI, SRAI
    assign uses_rs2 = (opcode == OPC_OP) || (opcode == OPC_BRANCH);

    always_comb begin
        case (opcode)
            OPC_OP:     alu_op = {instr[30], funct3};
            OPC_OP_IMM: alu_op = is_shift ? {instr[30], funct3} : {1'b0, funct3};
            default:    alu_op = '0;                  // Plain add for AUIPC
        endcase
    end

    // Second ALU operand when rs2 is not a source
    always_comb begin
        if (opcode == OPC_AUIPC) begin
            alu_imm_operand = u_imm;
        end else if (opcode == OPC_OP_IMM && is_shift) begin
            alu_imm_operand = {27'b0, instr[24:20]};  // shamt
        end else begin
            alu_imm_operand = i_imm;
        end
    end

endmodule

//--- source/issue_pkg.sv
package issue_pkg;

    typedef logic [31:0] word_t;     // Data value or address
    typedef logic [3:0]  rob_id_t;   // ROB tag with 0 for no dependency
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  alu_op_t;   // {funct7[5], funct3}
    typedef logic [2:0]  bcu_op_t;   // funct3
    typedef logic        rob_op_t;
    typedef logic [6:0]  opcode_t;

    localparam int NUM_REGS = 32;

    // ROB entry kinds
    localparam rob_op_t ROB_OP_OTHER  = 1'b0;
    localparam rob_op_t ROB_OP_BRANCH = 1'b1;

    // RV32I major opcodes kept by the issue stage
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    typedef enum logic [1:0] {
        ST_TRY_ISSUE,   // Take a new instruction from the fetcher
        ST_ISSUE_HELD,  // Retry the instruction stalled on a full unit
        ST_SKIP_ONE     // Drop the slot after a redirect
    } issue_state_t;

endpackage
